// ==== design/bundle_pkg.sv ====
// Shared widths and slot field positions; one bundle is three 16-bit slots, slot 0 in the low bits
package bundle_pkg;

	// ==============================
	// Slot and bundle geometry
	// ==============================
	localparam int SLOT_W    = 16;
	localparam int NUM_SLOTS = 3;
	localparam int BUNDLE_W  = SLOT_W * NUM_SLOTS;

	// Most slots queued in one cycle
	localparam int WAYS = 3;

	// ==============================
	// Memory and queue sizes
	// ==============================
	localparam int ADDR_W    = 6;
	localparam int MEM_DEPTH = 64;

	// Queue depth must be a power of two, pointers use QCNT_W-1 bits
	localparam int QUEUE_DEPTH = 8;
	localparam int QCNT_W      = 4;

	// ==============================
	// Slot field positions
	// ==============================
	// Unconditional jump or call
	localparam int JC_BIT    = 15;
	// Branch, and its taken flag
	localparam int BR_BIT    = 14;
	localparam int TAKEN_BIT = 13;
	// Entry slot of the target bundle, 2 bits, value 3 means slot 0
	localparam int TGT_SLOT_LSB = 6;
	// Target bundle address, ADDR_W bits
	localparam int TGT_ADDR_LSB = 0;

endpackage

// ==== design/bundle_mem_arbiter.sv ====
// Single-port bundle memory, writer always wins; reads return one cycle after grant, no init
`timescale 1ns/1ps

module bundle_mem_arbiter (
	input  logic                          clk,
	input  logic                          rst,
	// Loader side
	input  logic                          wr_req,
	input  logic [bundle_pkg::ADDR_W-1:0] wr_addr,
	input  logic [bundle_pkg::BUNDLE_W-1:0] wr_data,
	output logic                          wr_gnt,
	// Fetcher side
	input  logic                          rd_req,
	input  logic [bundle_pkg::ADDR_W-1:0] rd_addr,
	output logic                          rd_gnt,
	output logic                          rd_valid,
	output logic [bundle_pkg::BUNDLE_W-1:0] rd_data
);

	// Bundle storage
	logic [bundle_pkg::BUNDLE_W-1:0] mem [bundle_pkg::MEM_DEPTH];

	// ==============================
	// Fixed priority grant
	// ==============================
	// Loader first, fetcher only on a free cycle
	assign wr_gnt = wr_req;
	assign rd_gnt = rd_req & ~wr_req;

	// Write lands at the edge of the grant cycle
	always_ff @(posedge clk) begin
		if (wr_gnt)
			mem[wr_addr] <= wr_data;
	end

	// ==============================
	// Read port
	// ==============================
	// Data register holds the last granted read
	always_ff @(posedge clk) begin
		if (rd_gnt)
			rd_data <= mem[rd_addr];
	end

	// Valid marks the cycle after a grant
	always_ff @(posedge clk) begin
		if (rst)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_gnt;
	end

endmodule

// ==== design/debug_loader.sv ====
// One pending external write at a time; strobes that arrive while load_busy is high are dropped
`timescale 1ns/1ps

module debug_loader (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            load_valid,
	input  logic [bundle_pkg::ADDR_W-1:0]   load_addr,
	input  logic [bundle_pkg::BUNDLE_W-1:0] load_data,
	output logic                            wr_req,
	output logic [bundle_pkg::ADDR_W-1:0]   wr_addr,
	output logic [bundle_pkg::BUNDLE_W-1:0] wr_data,
	input  logic                            wr_gnt,
	output logic                            debug_on,
	output logic                            load_busy
);

	logic pending;

	// Pending flag, set by a strobe, cleared by the grant
	always_ff @(posedge clk) begin
		if (rst)
			pending <= 1'b0;
		else if (pending && wr_gnt)
			pending <= 1'b0;
		else if (load_valid && !pending)
			pending <= 1'b1;
	end

	// Capture address and data with the accepted strobe
	always_ff @(posedge clk) begin
		if (load_valid && !pending) begin
			wr_addr <= load_addr;
			wr_data <= load_data;
		end
	end

	// Request held as a level until granted
	assign wr_req    = pending;
	// Narrow issue while a load waits, and tell the source we are full
	assign debug_on  = pending;
	assign load_busy = pending;

endmodule

// ==== design/bundle_fetch.sv ====
// Fetch pointer and bundle register; one read in flight, redirect drops it, no prediction
`timescale 1ns/1ps

module bundle_fetch (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            redirect,
	input  logic [bundle_pkg::ADDR_W-1:0]   redirect_addr,
	output logic                            rd_req,
	output logic [bundle_pkg::ADDR_W-1:0]   rd_addr,
	input  logic                            rd_gnt,
	input  logic                            rd_valid,
	input  logic [bundle_pkg::BUNDLE_W-1:0] rd_data,
	output logic [bundle_pkg::BUNDLE_W-1:0] bundle,
	output logic                            phit,
	output logic [2:0]                      ip_mask,
	output logic [2:0]                      slot_jc,
	output logic [2:0]                      take_branch,
	input  logic                            advance,
	input  logic                            taken,
	input  logic [1:0]                      taken_slot
);

	logic [bundle_pkg::ADDR_W-1:0] fetch_addr;
	logic [1:0]                    entry_slot;
	logic                          wait_q;
	logic [bundle_pkg::SLOT_W-1:0] tgt_word;
	logic [1:0]                    tgt_entry;

	// ==============================
	// Slot decode
	// ==============================
	always_comb begin
		tgt_word = bundle[0 +: bundle_pkg::SLOT_W];
		for (int i = 0; i < bundle_pkg::NUM_SLOTS; i++) begin
			// Control bits per slot
			slot_jc[i]     = bundle[i*bundle_pkg::SLOT_W + bundle_pkg::JC_BIT];
			take_branch[i] = bundle[i*bundle_pkg::SLOT_W + bundle_pkg::BR_BIT]
				& bundle[i*bundle_pkg::SLOT_W + bundle_pkg::TAKEN_BIT];
			// Slots at or after the entry slot
			ip_mask[i]     = (2'(i) >= entry_slot);
			if (taken_slot == 2'(i))
				tgt_word = bundle[i*bundle_pkg::SLOT_W +: bundle_pkg::SLOT_W];
		end
		tgt_entry = tgt_word[bundle_pkg::TGT_SLOT_LSB +: 2];
		// Entry value 3 folds to slot 0
		if (tgt_entry == 2'd3)
			tgt_entry = 2'd0;
	end

	assign rd_addr = fetch_addr;

	// ==============================
	// Fetch control
	// ==============================
	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_addr <= '0;
			entry_slot <= 2'd0;
			rd_req     <= 1'b0;
			wait_q     <= 1'b0;
			phit       <= 1'b0;
		end else if (redirect) begin
			// Restart, a read in flight is ignored since wait_q drops
			fetch_addr <= redirect_addr;
			entry_slot <= 2'd0;
			rd_req     <= 1'b1;
			wait_q     <= 1'b0;
			phit       <= 1'b0;
		end else if (rd_req && rd_gnt) begin
			rd_req <= 1'b0;
			wait_q <= 1'b1;
		end else if (wait_q && rd_valid) begin
			wait_q <= 1'b0;
			phit   <= 1'b1;
		end else if (phit && advance) begin
			phit   <= 1'b0;
			rd_req <= 1'b1;
			if (taken) begin
				fetch_addr <= tgt_word[bundle_pkg::TGT_ADDR_LSB +: bundle_pkg::ADDR_W];
				entry_slot <= tgt_entry;
			end else begin
				// Sequential, wraps at the top of memory
				fetch_addr <= fetch_addr + bundle_pkg::ADDR_W'(1);
				entry_slot <= 2'd0;
			end
		end else if (!phit && !rd_req && !wait_q) begin
			// First request out of reset
			rd_req <= 1'b1;
		end
	end

	// Bundle register loads with the returning read
	always_ff @(posedge clk) begin
		if (wait_q && rd_valid && !redirect)
			bundle <= rd_data;
	end

endmodule

// ==== design/slot_valid.sv ====
// Slot issue tracker; queues lowest pending slots only, stops at the first control transfer
`timescale 1ns/1ps

module slot_valid (
	input  logic       clk,
	input  logic       rst,
	input  logic       redirect,
	input  logic       phit,
	input  logic [2:0] ip_mask,
	input  logic       canq1,
	input  logic       canq2,
	input  logic       canq3,
	input  logic [2:0] slot_jc,
	input  logic [2:0] take_branch,
	input  logic       debug_on,
	output logic [2:0] slotv,
	output logic [2:0] enq_mask,
	output logic       advance,
	output logic       taken,
	output logic [1:0] taken_slot
);

	logic [2:0] pat;
	logic [2:0] sel;
	logic [2:0] xfer;
	logic [1:0] lim;
	logic [1:0] cnt;
	logic       found;

	// Pending slots of a live bundle, none in a redirect cycle
	assign pat = slotv & ip_mask & {3{phit & ~redirect}};

	// ==============================
	// How many this cycle
	// ==============================
	always_comb begin
		lim = 2'd0;
		if (canq3 && !debug_on && bundle_pkg::WAYS > 2)
			lim = 2'd3;
		else if (canq2 && !debug_on && bundle_pkg::WAYS > 1)
			lim = 2'd2;
		else if (canq1)
			lim = 2'd1;
	end

	// Lowest pending slots, up to the limit
	always_comb begin
		sel = 3'b000;
		cnt = 2'd0;
		for (int i = 0; i < bundle_pkg::NUM_SLOTS; i++) begin
			if (pat[i] && cnt < lim) begin
				sel[i] = 1'b1;
				cnt    = cnt + 2'd1;
			end
		end
	end

	// ==============================
	// Control transfer cut
	// ==============================
	// Only the selected slots are tested
	assign xfer = sel & (slot_jc | take_branch);

	always_comb begin
		enq_mask   = sel;
		taken      = 1'b0;
		taken_slot = 2'd0;
		found      = 1'b0;
		for (int i = 0; i < bundle_pkg::NUM_SLOTS; i++) begin
			if (found)
				enq_mask[i] = 1'b0;
			else if (xfer[i]) begin
				// Keep the transferring slot, drop the ones after it
				found      = 1'b1;
				taken      = 1'b1;
				taken_slot = 2'(i);
			end
		end
	end

	// Done when nothing is left behind or control leaves the bundle
	assign advance = (sel != 3'b000) && (taken || (pat & ~sel) == 3'b000);

	// Queued slots go invalid, a finished bundle restores all
	always_ff @(posedge clk) begin
		if (rst || redirect)
			slotv <= 3'b111;
		else if (advance)
			slotv <= 3'b111;
		else
			slotv <= slotv & ~enq_mask;
	end

endmodule

// ==== design/issue_queue.sv ====
// Circular slot queue, up to three in and one out per cycle; room levels ignore a same-cycle pop
`timescale 1ns/1ps

module issue_queue (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            redirect,
	input  logic [bundle_pkg::BUNDLE_W-1:0] bundle,
	input  logic [2:0]                      enq_mask,
	input  logic                            deq,
	output logic                            canq1,
	output logic                            canq2,
	output logic                            canq3,
	output logic                            out_valid,
	output logic [bundle_pkg::SLOT_W-1:0]   out_slot
);

	logic [bundle_pkg::SLOT_W-1:0] q_mem [bundle_pkg::QUEUE_DEPTH];
	logic [bundle_pkg::QCNT_W-2:0] wr_ptr;
	logic [bundle_pkg::QCNT_W-2:0] rd_ptr;
	logic [bundle_pkg::QCNT_W-1:0] count;
	logic [bundle_pkg::QCNT_W-1:0] n_enq;
	logic [bundle_pkg::QCNT_W-2:0] wr_idx [bundle_pkg::NUM_SLOTS];
	logic                          pop;

	// ==============================
	// Write positions
	// ==============================
	// Each masked slot goes after the masked slots below it
	always_comb begin
		n_enq = '0;
		for (int i = 0; i < bundle_pkg::NUM_SLOTS; i++) begin
			wr_idx[i] = wr_ptr + n_enq[bundle_pkg::QCNT_W-2:0];
			n_enq     = n_enq + bundle_pkg::QCNT_W'(enq_mask[i]);
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < bundle_pkg::NUM_SLOTS; i++) begin
			if (enq_mask[i] && !redirect)
				q_mem[wr_idx[i]] <= bundle[i*bundle_pkg::SLOT_W +: bundle_pkg::SLOT_W];
		end
	end

	// ==============================
	// Pointers and occupancy
	// ==============================
	assign out_valid = (count != '0);
	assign out_slot  = q_mem[rd_ptr];
	assign pop       = deq & out_valid;

	always_ff @(posedge clk) begin
		if (rst || redirect) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			wr_ptr <= wr_ptr + n_enq[bundle_pkg::QCNT_W-2:0];
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + n_enq - bundle_pkg::QCNT_W'(pop);
		end
	end

	// Room levels for the tracker
	assign canq1 = (count <= bundle_pkg::QCNT_W'(bundle_pkg::QUEUE_DEPTH - 1));
	assign canq2 = (count <= bundle_pkg::QCNT_W'(bundle_pkg::QUEUE_DEPTH - 2));
	assign canq3 = (count <= bundle_pkg::QCNT_W'(bundle_pkg::QUEUE_DEPTH - 3));

endmodule

// ==== design/frontend_top.sv ====
// Front end top; loads always win the memory, so fetch stalls while loads stream in
`timescale 1ns/1ps

module frontend_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            load_valid,
	input  logic [bundle_pkg::ADDR_W-1:0]   load_addr,
	input  logic [bundle_pkg::BUNDLE_W-1:0] load_data,
	input  logic                            redirect,
	input  logic [bundle_pkg::ADDR_W-1:0]   redirect_addr,
	input  logic                            deq,
	output logic                            load_busy,
	output logic                            out_valid,
	output logic [bundle_pkg::SLOT_W-1:0]   out_slot
);

	// ==============================
	// Interconnect
	// ==============================
	// Loader and memory
	logic                            wr_req, wr_gnt, debug_on;
	logic [bundle_pkg::ADDR_W-1:0]   wr_addr;
	logic [bundle_pkg::BUNDLE_W-1:0] wr_data;
	// Fetcher and memory
	logic                            rd_req, rd_gnt, rd_valid;
	logic [bundle_pkg::ADDR_W-1:0]   rd_addr;
	logic [bundle_pkg::BUNDLE_W-1:0] rd_data;
	// Fetcher, tracker and queue
	logic [bundle_pkg::BUNDLE_W-1:0] bundle;
	logic                            phit, advance, taken;
	logic [2:0]                      ip_mask, slot_jc, take_branch, slotv, enq_mask;
	logic [1:0]                      taken_slot;
	logic                            canq1, canq2, canq3;

	bundle_mem_arbiter i_mem (.clk, .rst, .wr_req, .wr_addr, .wr_data, .wr_gnt,
		.rd_req, .rd_addr, .rd_gnt, .rd_valid, .rd_data);

	debug_loader i_loader (.clk, .rst, .load_valid, .load_addr, .load_data,
		.wr_req, .wr_addr, .wr_data, .wr_gnt, .debug_on, .load_busy);

	bundle_fetch i_fetch (.clk, .rst, .redirect, .redirect_addr, .rd_req, .rd_addr,
		.rd_gnt, .rd_valid, .rd_data, .bundle, .phit, .ip_mask, .slot_jc,
		.take_branch, .advance, .taken, .taken_slot);

	slot_valid i_slotv (.clk, .rst, .redirect, .phit, .ip_mask, .canq1, .canq2,
		.canq3, .slot_jc, .take_branch, .debug_on, .slotv, .enq_mask, .advance,
		.taken, .taken_slot);

	issue_queue i_queue (.clk, .rst, .redirect, .bundle, .enq_mask, .deq,
		.canq1, .canq2, .canq3, .out_valid, .out_slot);

endmodule

// ==== verification/frontend_assert.sv ====
// Bound into issue_queue and bundle_mem_arbiter; tie unused ports to zero in the bind
`timescale 1ns/1ps

module frontend_assert (
	input logic                            clk,
	input logic                            rst,
	input logic [bundle_pkg::QCNT_W-1:0]   occupancy,
	input logic                            gnt_wr,
	input logic                            gnt_rd
);

	// Failures seen so far, read by the testbench report
	int fail_count = 0;

	// ==============================
	// Queue occupancy
	// ==============================
	a_occupancy: assert property (@(posedge clk) disable iff (rst)
		occupancy <= bundle_pkg::QCNT_W'(bundle_pkg::QUEUE_DEPTH))
		else begin
			fail_count++;
			$error("queue occupancy above depth");
		end

	// ==============================
	// Arbiter grants
	// ==============================
	// One master per cycle
	a_one_grant: assert property (@(posedge clk) disable iff (rst) !(gnt_wr && gnt_rd))
		else begin
			fail_count++;
			$error("both masters granted in one cycle");
		end

endmodule

// Queue instance checks occupancy only
bind issue_queue frontend_assert i_queue_assert (
	.clk(clk), .rst(rst), .occupancy(count), .gnt_wr(1'b0), .gnt_rd(1'b0));

// Arbiter instance checks the grants only
bind bundle_mem_arbiter frontend_assert i_mem_assert (
	.clk(clk), .rst(rst), .occupancy('0), .gnt_wr(wr_gnt), .gnt_rd(rd_gnt));

// ==== verification/frontend_checker.sv ====
// Reference program walk from bundle 0 after reset; memory must be loaded before the first pop
`timescale 1ns/1ps

module frontend_checker (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            load_valid,
	input  logic [bundle_pkg::ADDR_W-1:0]   load_addr,
	input  logic [bundle_pkg::BUNDLE_W-1:0] load_data,
	input  logic                            load_busy,
	input  logic                            redirect,
	input  logic [bundle_pkg::ADDR_W-1:0]   redirect_addr,
	input  logic                            deq,
	input  logic                            out_valid,
	input  logic [bundle_pkg::SLOT_W-1:0]   out_slot,
	output int                              errors,
	output int                              pops
);

	// Mirror of bundle memory, from accepted load strobes
	logic [bundle_pkg::BUNDLE_W-1:0] mirror [bundle_pkg::MEM_DEPTH];
	logic [bundle_pkg::ADDR_W-1:0]   exp_addr;
	logic [1:0]                      exp_slot;
	logic [bundle_pkg::SLOT_W-1:0]   exp_word;
	logic [1:0]                      entry;
	logic                            busy_model;
	logic                            hold_expect;
	int                              n_err;

	// Slot the program walk expects next
	assign exp_word = mirror[exp_addr][int'(exp_slot)*bundle_pkg::SLOT_W +: bundle_pkg::SLOT_W];
	assign entry    = exp_word[bundle_pkg::TGT_SLOT_LSB +: 2];

	always @(posedge clk) begin
		n_err = errors;
		// A strobe counts only when the modeled loader is idle
		if (load_valid && !busy_model)
			mirror[load_addr] <= load_data;

		// ==============================
		// Loader busy flag
		// ==============================
		// Loader is granted at once and stays busy for one cycle only
		if (rst) begin
			busy_model <= 1'b0;
		end else begin
			if (load_busy !== busy_model) begin
				n_err++;
				$display("FAIL %0t: load_busy %b, expected %b",
					$time, load_busy, busy_model);
			end
			busy_model <= load_valid && !busy_model;
		end

		if (rst) begin
			hold_expect <= 1'b0;
			exp_addr    <= '0;
			exp_slot    <= 2'd0;
			n_err       = 0;
			pops        <= 0;
		end else if (redirect) begin
			// Restart at slot 0, a pop in this cycle is dropped by the queue
			exp_addr    <= redirect_addr;
			exp_slot    <= 2'd0;
			hold_expect <= 1'b0;
		end else begin
			// ==============================
			// Held queue stays valid
			// ==============================
			if (hold_expect && !out_valid) begin
				n_err++;
				$display("FAIL %0t: out_valid dropped with no pop", $time);
			end
			hold_expect <= out_valid && !deq;

			// ==============================
			// Pop compare and walk
			// ==============================
			if (deq && out_valid) begin
				pops <= pops + 1;
				if (out_slot !== exp_word) begin
					n_err++;
					$display("FAIL %0t: bundle %0d slot %0d popped %h, expected %h",
						$time, exp_addr, exp_slot, out_slot, exp_word);
				end
				if (exp_word[bundle_pkg::JC_BIT] ||
					(exp_word[bundle_pkg::BR_BIT] && exp_word[bundle_pkg::TAKEN_BIT])) begin
					// Jump or taken branch, entry 3 means slot 0
					exp_addr <= exp_word[bundle_pkg::TGT_ADDR_LSB +: bundle_pkg::ADDR_W];
					exp_slot <= (entry == 2'd3) ? 2'd0 : entry;
				end else if (exp_slot == 2'd2) begin
					// Next bundle, wraps at the top
					exp_slot <= 2'd0;
					exp_addr <= exp_addr + 1'b1;
				end else begin
					exp_slot <= exp_slot + 2'd1;
				end
			end
		end
		errors <= n_err;
	end

endmodule

// ==== verification/frontend_tb.sv ====
// Testbench top; memory is fully loaded and then redirected to 0 before any pop is checked
`timescale 1ns/1ps

module frontend_tb;

	localparam int RESET_CYCLES = 16;
	localparam int TIMEOUT      = 3000;

	logic                            clk = 1'b0;
	logic                            rst;
	logic                            load_valid;
	logic [bundle_pkg::ADDR_W-1:0]   load_addr;
	logic [bundle_pkg::BUNDLE_W-1:0] load_data;
	logic                            redirect;
	logic [bundle_pkg::ADDR_W-1:0]   redirect_addr;
	logic                            deq;
	logic                            load_busy;
	logic                            out_valid;
	logic [bundle_pkg::SLOT_W-1:0]   out_slot;
	int                              errors;
	int                              pops;

	// Program image as loaded, reused for the reload test
	logic [bundle_pkg::BUNDLE_W-1:0] prog [bundle_pkg::MEM_DEPTH];
	logic [31:0]                     lfsr = 32'd87462;
	int                              tests_run = 0;
	int                              tests_failed = 0;
	int                              err_before;

	always #50 clk = ~clk;

	frontend_top i_dut (.clk, .rst, .load_valid, .load_addr, .load_data, .redirect,
		.redirect_addr, .deq, .load_busy, .out_valid, .out_slot);

	frontend_checker i_check (.clk, .rst, .load_valid, .load_addr, .load_data, .load_busy,
		.redirect, .redirect_addr, .deq, .out_valid, .out_slot, .errors, .pops);

	// ==============================
	// Random bits and slot building
	// ==============================
	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v    = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hA300_0000) : (lfsr >> 1);
		end
		return v;
	endfunction

	// About one slot in five transfers control
	function automatic logic [bundle_pkg::SLOT_W-1:0] make_slot(input logic no_xfer);
		logic [bundle_pkg::SLOT_W-1:0] s;
		s = bundle_pkg::SLOT_W'(take_bits(13));
		s[bundle_pkg::JC_BIT]    = (take_bits(3) == 0) && !no_xfer;
		s[bundle_pkg::BR_BIT]    = take_bits(1) != 0;
		s[bundle_pkg::TAKEN_BIT] = (take_bits(2) == 3) && !no_xfer;
		return s;
	endfunction

	function automatic int total_errors();
		return errors + i_dut.i_queue.i_queue_assert.fail_count
			+ i_dut.i_mem.i_mem_assert.fail_count;
	endfunction

	task automatic give_up(input string what);
		$display("Timeout while waiting for %s", what);
		$display("*** FAILED ***");
		$finish;
	endtask

	// ==============================
	// Stimulus tasks
	// ==============================
	task automatic wait_not_busy();
		int n;
		n = 0;
		@(negedge clk);
		while (load_busy) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				give_up("the loader to go idle");
		end
	endtask

	task automatic wait_valid();
		int n;
		n = 0;
		@(negedge clk);
		while (!out_valid) begin
			@(negedge clk);
			n++;
			if (n > TIMEOUT)
				give_up("out_valid");
		end
	endtask

	// One load; with junk, a second strobe hits while load_busy is high
	task automatic load_one(input logic [5:0] a, input logic [47:0] d, input logic junk);
		logic [bundle_pkg::ADDR_W-1:0]   junk_addr;
		logic [bundle_pkg::BUNDLE_W-1:0] junk_data;
		wait_not_busy();
		// Junk values, drawn while the clock is low
		junk_addr = bundle_pkg::ADDR_W'(take_bits(6));
		junk_data = {16'(take_bits(16)), take_bits(32)};
		@(posedge clk);
		load_valid <= 1'b1;
		load_addr  <= a;
		load_data  <= d;
		@(posedge clk);
		load_valid <= junk;
		load_addr  <= junk_addr;
		load_data  <= junk_data;
		@(posedge clk);
		load_valid <= 1'b0;
	endtask

	task automatic do_redirect(input logic [5:0] a);
		@(posedge clk);
		redirect      <= 1'b1;
		redirect_addr <= a;
		@(posedge clk);
		redirect      <= 1'b0;
	endtask

	// Pops n slots; deq is skipped one time in 2**deq_bits, redirects one in 2**redir_bits
	task automatic pop_run(input int n, input int deq_bits, input int redir_bits);
		int target;
		int cyc;
		target = pops + n;
		cyc    = 0;
		while (pops < target) begin
			@(posedge clk);
			deq <= (deq_bits == 0) ? 1'b1 : (take_bits(deq_bits) != 0);
			if (redir_bits > 0 && take_bits(redir_bits) == 0) begin
				redirect      <= 1'b1;
				redirect_addr <= bundle_pkg::ADDR_W'(take_bits(6));
			end else begin
				redirect <= 1'b0;
			end
			cyc++;
			if (cyc > TIMEOUT)
				give_up("popped slots");
		end
		@(posedge clk);
		deq      <= 1'b0;
		redirect <= 1'b0;
	endtask

	task automatic start_test();
		err_before = total_errors();
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		if (total_errors() > err_before) begin
			tests_failed++;
			$display("test %0d %s: fail", tests_run, name);
		end else begin
			$display("test %0d %s: ok", tests_run, name);
		end
	endtask

	// ==============================
	// Test sequence
	// ==============================
	initial begin
		rst           <= 1'b1;
		load_valid    <= 1'b0;
		load_addr     <= '0;
		load_data     <= '0;
		redirect      <= 1'b0;
		redirect_addr <= '0;
		deq           <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		// Bundles 56..63 and 0..3 run straight through
		start_test();
		for (int a = 0; a < bundle_pkg::MEM_DEPTH; a++) begin
			for (int s = 0; s < bundle_pkg::NUM_SLOTS; s++)
				prog[a][s*bundle_pkg::SLOT_W +: bundle_pkg::SLOT_W] =
					make_slot(a >= 56 || a < 4);
			load_one(6'(a), prog[a], (a % 4) == 0);
		end
		do_redirect(6'd0);
		pop_run(60, 1, 0);
		finish_test("load and run");

		start_test();
		do_redirect(6'd56);
		pop_run(30, 0, 0);
		finish_test("sequential wrap");

		start_test();
		do_redirect(6'(take_bits(6)));
		pop_run(200, 2, 0);
		finish_test("transfers");

		// Long stretches with no pops
		start_test();
		do_redirect(6'd5);
		wait_valid();
		repeat (60) @(posedge clk);
		pop_run(40, 0, 0);
		repeat (30) @(posedge clk);
		pop_run(40, 3, 0);
		finish_test("back-pressure");

		start_test();
		repeat (8) begin
			do_redirect(6'(take_bits(6)));
			wait_valid();
			pop_run(5, 1, 0);
		end
		pop_run(150, 1, 5);
		finish_test("redirects");

		// Same data reloaded under traffic, junk strobes must be dropped
		start_test();
		do_redirect(6'd0);
		fork
			pop_run(150, 1, 0);
			for (int a = 0; a < bundle_pkg::MEM_DEPTH; a++)
				load_one(6'(a), prog[a], 1'b1);
		join
		pop_run(60, 1, 0);
		finish_test("reload under traffic");

		$display("tests %0d, failed %0d, errors %0d, pops %0d",
			tests_run, tests_failed, total_errors(), pops);
		if (tests_failed == 0 && total_errors() == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// ==== filelist.f ====
design/bundle_pkg.sv
design/bundle_mem_arbiter.sv
design/debug_loader.sv
design/bundle_fetch.sv
design/slot_valid.sv
design/issue_queue.sv
design/frontend_top.sv
verification/frontend_assert.sv
verification/frontend_checker.sv
verification/frontend_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing -Wno-fatal
TOP       = frontend_tb
FILELIST  = filelist.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf obj_dir $(LOG)
